/* source/acq_pkg.sv */
package acq_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int APB_AW      = 8;                        // apb byte address
    localparam int APB_DW      = 32;                       // apb data bus
    localparam int SAMPLE_W    = 12;                       // adc resolution
    localparam int TAG_W       = 16;                       // channel tag
    localparam int FILL_NUM_W  = 24;                       // fill number
    localparam int WAVE_W      = 12;                       // waveform index and total
    localparam int BURST_MAX_W = 23;                       // widest burst count field

    localparam logic [3:0] HDR_KIND = 4'hA;                // marks a header word

    // register map, byte addresses
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;     // enable, fill type
    localparam logic [APB_AW-1:0] ADDR_TAG    = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_MUON   = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_LASER  = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_PED    = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_INIT   = 8'h14;     // initial fill number
    localparam logic [APB_AW-1:0] ADDR_WAVES  = 8'h18;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h1C;     // fill num, busy, overrun

    typedef enum logic [1:0] {
        FILL_MUON  = 2'd0,
        FILL_LASER = 2'd1,
        FILL_PED   = 2'd2,
        FILL_NONE  = 2'd3                                  // reserved, no fill
    } fill_type_e;

    typedef struct packed {
        logic [3:0]             kind;                      // always HDR_KIND
        logic [FILL_NUM_W-1:0]  fill_num;
        fill_type_e             fill_type;
        logic [TAG_W-1:0]       chan_tag;
        logic [BURST_MAX_W-1:0] burst_cnt;                 // data words per waveform
        logic [WAVE_W-1:0]      wave_idx;
        logic [WAVE_W-1:0]      wave_total;
        logic [34:0]            rsvd;                      // zero
    } acq_header_t;

    typedef struct packed {
        logic [2:0]          pad;                          // zero, keeps lane 7 off 4'hA
        logic                ovr;                          // adc over-range
        logic [SAMPLE_W-1:0] sample;
    } acq_lane_t;

    typedef struct packed {
        acq_lane_t [7:0] lane;                             // lane 0 is the earliest sample
    } acq_data_t;

    typedef union packed {
        acq_header_t hdr;
        acq_data_t   data;
    } acq_word_u;

    typedef struct packed {
        logic                   enable;
        fill_type_e             fill_type;
        logic [TAG_W-1:0]       chan_tag;
        logic [BURST_MAX_W-1:0] muon_bursts;
        logic [BURST_MAX_W-1:0] laser_bursts;
        logic [BURST_MAX_W-1:0] ped_bursts;
        logic [WAVE_W-1:0]      num_waves;                 // waveforms per trigger
    } acq_cfg_t;

endpackage

/* source/acq_regs.sv */
`timescale 1ns/1ps

module acq_regs import acq_pkg::*; #(
    parameter int BURST_W = 23                             // valid bits of each burst count
) (
    input  logic                  adc_clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_AW-1:0]     paddr,
    input  logic [APB_DW-1:0]     pwdata,
    input  logic [FILL_NUM_W-1:0] fill_num,                // current fill number
    input  logic                  busy,
    input  logic                  overrun,
    output logic [APB_DW-1:0]     prdata,
    output logic                  pready,
    output acq_cfg_t              cfg,
    output logic                  init_fill_wr,            // one cycle, with init_fill_num
    output logic [FILL_NUM_W-1:0] init_fill_num,
    output logic                  overrun_clr              // one cycle, status write
);

    logic wr_en;                                           // apb access phase write

    assign pready = 1'b1;                                  // no wait states
    assign wr_en  = psel && penable && pwrite;

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////
    always_ff @(posedge adc_clk) begin
        init_fill_wr <= 1'b0;                              // pulses
        overrun_clr  <= 1'b0;
        if (reset) begin
            cfg           <= '0;                           // disabled, muon, all counts 0
            init_fill_num <= '0;
        end else if (wr_en) begin
            case (paddr)
                ADDR_CTRL: begin
                    cfg.enable    <= pwdata[0];
                    cfg.fill_type <= fill_type_e'(pwdata[2:1]);
                end
                ADDR_TAG:    cfg.chan_tag     <= pwdata[TAG_W-1:0];
                ADDR_MUON:   cfg.muon_bursts  <= BURST_MAX_W'(pwdata[BURST_W-1:0]);
                ADDR_LASER:  cfg.laser_bursts <= BURST_MAX_W'(pwdata[BURST_W-1:0]);
                ADDR_PED:    cfg.ped_bursts   <= BURST_MAX_W'(pwdata[BURST_W-1:0]);
                ADDR_INIT: begin
                    init_fill_num <= pwdata[FILL_NUM_W-1:0];
                    init_fill_wr  <= 1'b1;                 // header gen loads next cycle
                end
                ADDR_WAVES:  cfg.num_waves    <= pwdata[WAVE_W-1:0];
                ADDR_STATUS: overrun_clr      <= 1'b1;     // any write clears overrun
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // read mux, valid in the access phase
    ////////////////////////////////////////
    always_comb begin
        case (paddr)
            ADDR_CTRL:   prdata = {29'd0, cfg.fill_type, cfg.enable};
            ADDR_TAG:    prdata = {16'd0, cfg.chan_tag};
            ADDR_MUON:   prdata = APB_DW'(cfg.muon_bursts);
            ADDR_LASER:  prdata = APB_DW'(cfg.laser_bursts);
            ADDR_PED:    prdata = APB_DW'(cfg.ped_bursts);
            ADDR_INIT:   prdata = APB_DW'(init_fill_num);
            ADDR_WAVES:  prdata = APB_DW'(cfg.num_waves);
            ADDR_STATUS: prdata = {6'd0, overrun, busy, fill_num};
            default:     prdata = '0;
        endcase
    end

    // apb access phase always follows a setup phase on the same select
    a_penable_psel: assert property (@(posedge adc_clk) disable iff (reset)
        penable |-> psel);

endmodule

/* source/acq_header_gen.sv */
`timescale 1ns/1ps

module acq_header_gen import acq_pkg::*; #(
    parameter int BURST_W = 23
) (
    input  logic                  adc_clk,
    input  logic                  reset,
    input  acq_cfg_t              cfg,
    input  logic                  init_fill_wr,
    input  logic [FILL_NUM_W-1:0] init_fill_num,
    input  logic                  fill_start,              // trigger accepted this cycle
    input  logic                  fill_end,                // last waveform drained
    input  logic [WAVE_W-1:0]     wave_idx,
    output acq_header_t           hdr_word,
    output logic [FILL_NUM_W-1:0] fill_num
);

    fill_type_e           type_q;                          // config frozen for the fill
    logic [TAG_W-1:0]     tag_q;
    logic [BURST_W-1:0]   burst_q;
    logic [WAVE_W-1:0]    waves_q;
    logic [BURST_W-1:0]   burst_sel;                       // count for the requested type

    always_comb begin
        case (cfg.fill_type)
            FILL_MUON:  burst_sel = cfg.muon_bursts[BURST_W-1:0];
            FILL_LASER: burst_sel = cfg.laser_bursts[BURST_W-1:0];
            FILL_PED:   burst_sel = cfg.ped_bursts[BURST_W-1:0];
            default:    burst_sel = '0;                    // never accepted
        endcase
    end

    always_ff @(posedge adc_clk) begin
        if (fill_start) begin
            type_q  <= cfg.fill_type;
            tag_q   <= cfg.chan_tag;
            burst_q <= burst_sel;
            waves_q <= cfg.num_waves;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            fill_num <= '0;
        end else if (init_fill_wr) begin
            fill_num <= init_fill_num;                     // wins over a fill end
        end else if (fill_end) begin
            fill_num <= fill_num + 1'b1;
        end
    end

    // first header is built straight from cfg in the trigger cycle
    always_comb begin
        hdr_word            = '0;
        hdr_word.kind       = HDR_KIND;
        hdr_word.fill_num   = fill_num;
        hdr_word.fill_type  = fill_start ? cfg.fill_type : type_q;
        hdr_word.chan_tag   = fill_start ? cfg.chan_tag : tag_q;
        hdr_word.burst_cnt  = BURST_MAX_W'(fill_start ? burst_sel : burst_q);
        hdr_word.wave_idx   = wave_idx;
        hdr_word.wave_total = fill_start ? cfg.num_waves : waves_q;
    end

endmodule

/* source/acq_sample_packer.sv */
`timescale 1ns/1ps

module acq_sample_packer import acq_pkg::*; (
    input  logic                adc_clk,
    input  logic                reset,
    input  logic [SAMPLE_W-1:0] adc_data,
    input  logic                adc_ovr,
    input  logic                capture_en,                // held high for a whole waveform
    output acq_data_t           pack_word,
    output logic                pack_valid                 // one cycle per eight samples
);

    logic [2:0] lane_cnt;                                  // next lane to fill
    acq_lane_t  lane_in;

    always_comb begin
        lane_in        = '0;                               // zero pad
        lane_in.ovr    = adc_ovr;
        lane_in.sample = adc_data;
    end

    ////////////////////////////////////////
    // shift in at the top, lane 0 ends up oldest
    ////////////////////////////////////////
    always_ff @(posedge adc_clk) begin
        if (capture_en) begin
            pack_word.lane <= {lane_in, pack_word.lane[7:1]};
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            lane_cnt   <= '0;
            pack_valid <= 1'b0;
        end else begin
            pack_valid <= capture_en && (lane_cnt == 3'd7);    // eighth lane filled
            if (capture_en) begin
                lane_cnt <= lane_cnt + 1'b1;               // wraps to 0 after a word
            end else begin
                lane_cnt <= '0;                            // restart on next rise
            end
        end
    end

    // a word needs eight samples taken since capture started
    a_eight_samples: assert property (@(posedge adc_clk) disable iff (reset)
        pack_valid |-> $past(capture_en, 8));

endmodule

/* source/acq_sequencer.sv */
`timescale 1ns/1ps

module acq_sequencer import acq_pkg::*; #(
    parameter int BURST_W = 23
) (
    input  logic              adc_clk,
    input  logic              reset,
    input  acq_cfg_t          cfg,
    input  logic              acq_trig,
    input  acq_header_t       hdr_word,
    input  acq_data_t         pack_word,
    input  logic              pack_valid,
    input  logic              out_ready,
    input  logic              overrun_clr,
    output logic              fill_start,
    output logic              fill_end,
    output logic [WAVE_W-1:0] wave_idx,                    // index of the next header
    output logic              capture_en,
    output acq_word_u         acq_out,                     // holding register
    output logic              out_valid,
    output logic              acq_done,
    output logic              busy,
    output logic              overrun                      // sticky, word dropped
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,                                             // header held, waiting to go
        S_DATA,                                            // capturing a waveform
        S_DONE                                             // draining the last data word
    } state_e;

    state_e             state;
    logic [BURST_W-1:0] burst_q;                           // data words produced
    logic [BURST_W-1:0] burst_total;
    logic               take;                              // word leaves this cycle
    logic               drained;                           // holding register free next cycle
    logic               last_wave;

    assign take        = out_valid && out_ready;
    assign drained     = !out_valid || take;
    assign burst_total = hdr_word.burst_cnt[BURST_W-1:0];
    assign last_wave   = (wave_idx >= hdr_word.wave_total);
    assign busy        = (state != S_IDLE);
    assign fill_start  = (state == S_IDLE) && acq_trig && cfg.enable
                         && (cfg.fill_type != FILL_NONE);
    assign fill_end    = (state == S_DONE) && drained && last_wave;

    always_ff @(posedge adc_clk) begin
        if (take) out_valid <= 1'b0;                       // loads below override
        acq_done <= 1'b0;
        if (overrun_clr) overrun <= 1'b0;
        case (state)
            S_IDLE: if (fill_start) begin
                acq_out.hdr <= hdr_word;                   // wave 0, from cfg
                out_valid   <= 1'b1;
                state       <= S_HDR;
            end
            S_HDR: if (take) begin
                wave_idx <= wave_idx + 1'b1;
                burst_q  <= '0;
                if (burst_total == '0) begin
                    state <= S_DONE;                       // empty waveform
                end else begin
                    capture_en <= 1'b1;
                    state      <= S_DATA;
                end
            end
            S_DATA: if (pack_valid) begin
                if (drained) begin
                    acq_out.data <= pack_word;
                    out_valid    <= 1'b1;
                end else begin
                    overrun <= 1'b1;                       // word lost, count goes on
                end
                burst_q <= burst_q + 1'b1;
                if (burst_q == burst_total - 1'b1) begin
                    capture_en <= 1'b0;
                    state      <= S_DONE;
                end
            end
            S_DONE: if (drained) begin
                if (last_wave) begin
                    acq_done <= 1'b1;
                    wave_idx <= '0;
                    state    <= S_IDLE;
                end else begin
                    acq_out.hdr <= hdr_word;               // next waveform header
                    out_valid   <= 1'b1;
                    state       <= S_HDR;
                end
            end
            default: state <= S_IDLE;
        endcase
        if (reset) begin
            state      <= S_IDLE;
            out_valid  <= 1'b0;
            capture_en <= 1'b0;
            acq_done   <= 1'b0;
            overrun    <= 1'b0;
            wave_idx   <= '0;
            burst_q    <= '0;
        end
    end

    // a held word must not change before the sink takes it
    a_hold_stable: assert property (@(posedge adc_clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(acq_out));

endmodule

/* source/acq_top.sv */
`timescale 1ns/1ps

module acq_top import acq_pkg::*; #(
    parameter int BURST_W = 23                             // burst counter width
) (
    input  logic                adc_clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [APB_AW-1:0]   paddr,
    input  logic [APB_DW-1:0]   pwdata,
    output logic [APB_DW-1:0]   prdata,
    output logic                pready,
    input  logic [SAMPLE_W-1:0] adc_data,
    input  logic                adc_ovr,
    input  logic                acq_trig,
    output acq_word_u           acq_out,                   // header or data
    output logic                out_valid,
    input  logic                out_ready,
    output logic                acq_done
);

    acq_cfg_t              cfg;
    logic                  init_fill_wr;
    logic [FILL_NUM_W-1:0] init_fill_num;
    logic                  overrun_clr;
    logic [FILL_NUM_W-1:0] fill_num;
    logic                  busy, overrun;
    logic                  fill_start, fill_end;
    logic [WAVE_W-1:0]     wave_idx;
    acq_header_t           hdr_word;
    acq_data_t             pack_word;
    logic                  pack_valid, capture_en;

    acq_regs #(.BURST_W(BURST_W)) regs0 (.adc_clk, .reset, .psel, .penable, .pwrite,
        .paddr, .pwdata, .fill_num, .busy, .overrun, .prdata, .pready, .cfg,
        .init_fill_wr, .init_fill_num, .overrun_clr);

    acq_header_gen #(.BURST_W(BURST_W)) hdr0 (.adc_clk, .reset, .cfg, .init_fill_wr,
        .init_fill_num, .fill_start, .fill_end, .wave_idx, .hdr_word, .fill_num);

    acq_sample_packer pack0 (.adc_clk, .reset, .adc_data, .adc_ovr, .capture_en,
        .pack_word, .pack_valid);

    acq_sequencer #(.BURST_W(BURST_W)) seq0 (.adc_clk, .reset, .cfg, .acq_trig, .hdr_word,
        .pack_word, .pack_valid, .out_ready, .overrun_clr, .fill_start, .fill_end,
        .wave_idx, .capture_en, .acq_out, .out_valid, .acq_done, .busy, .overrun);

endmodule

/* tests/acq_checker.sv */
`timescale 1ns/1ps

module acq_checker import acq_pkg::*; (
    input logic      adc_clk,
    input logic      reset,
    input logic      psel,
    input logic      penable,
    input logic      pready,
    input acq_word_u acq_out,
    input logic      out_valid,
    input logic      out_ready,
    input logic      acq_done
);

    logic [127:0]          name_q;                         // current test name
    acq_cfg_t              cfg_q;                          // config written for the test
    logic [FILL_NUM_W-1:0] exp_fill    = '0;               // next expected fill number
    logic                  active      = 1'b0;
    logic                  gated       = 1'b0;             // trigger must be ignored
    logic                  lfsr_q      = 1'b0;             // random ready, drops possible
    logic                  in_wave     = 1'b0;
    logic                  have_prev   = 1'b0;             // a data word seen in this wave
    logic                  hold_q      = 1'b0;             // word was held last cycle
    acq_word_u             held_q;
    logic [SAMPLE_W-1:0]   last_sample;
    int                    test_err    = 0;
    int                    err_total   = 0;
    int                    tests_run   = 0;
    int                    tests_failed = 0;
    int                    soft_cnt    = 0;                // gaps that need an overrun
    int                    done_cnt    = 0;
    int                    wave_cnt    = 0;
    int                    data_cnt    = 0;

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0s %0s: expected %0h, actual %0h", name_q, field, expected,
                actual);
            test_err  = test_err + 1;
            err_total = err_total + 1;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%0s: %0s", name_q, msg);
        test_err  = test_err + 1;
        err_total = err_total + 1;
    endtask

    function automatic logic [BURST_MAX_W-1:0] burst_for_type(input acq_cfg_t c);
        case (c.fill_type)
            FILL_MUON:  return c.muon_bursts;
            FILL_LASER: return c.laser_bursts;
            default:    return c.ped_bursts;
        endcase
    endfunction

    task automatic start_test(input logic [127:0] name, input acq_cfg_t cfg,
                              input logic init_wr, input logic [FILL_NUM_W-1:0] init_fill,
                              input logic lfsr_on);
        name_q    = name;
        cfg_q     = cfg;
        if (init_wr) begin
            exp_fill = init_fill;                          // first fill takes the written value
        end
        gated     = !cfg.enable || (cfg.fill_type == FILL_NONE);
        lfsr_q    = lfsr_on;
        test_err  = 0;
        soft_cnt  = 0;
        done_cnt  = 0;
        wave_cnt  = 0;
        in_wave   = 1'b0;
        have_prev = 1'b0;
        active    = 1'b1;
    endtask

    task automatic close_wave();
        logic [BURST_MAX_W-1:0] burst;
        burst = burst_for_type(cfg_q);
        if (lfsr_q && 64'(data_cnt) < 64'(burst)) begin
            soft_cnt = soft_cnt + 1;                       // dropped words shorten the wave
        end else begin
            check_value("data_words", 64'(burst), 64'(data_cnt));
        end
        in_wave = 1'b0;
    endtask

    task automatic check_header(input acq_header_t h);
        if (in_wave) begin
            close_wave();
        end
        check_value("fill_num", 64'(exp_fill), 64'(h.fill_num));
        check_value("fill_type", 64'(cfg_q.fill_type), 64'(h.fill_type));
        check_value("chan_tag", 64'(cfg_q.chan_tag), 64'(h.chan_tag));
        check_value("burst_cnt", 64'(burst_for_type(cfg_q)), 64'(h.burst_cnt));
        check_value("wave_idx", 64'(wave_cnt), 64'(h.wave_idx));
        check_value("wave_total", 64'(cfg_q.num_waves), 64'(h.wave_total));
        check_value("rsvd", 64'd0, 64'(h.rsvd));
        wave_cnt  = wave_cnt + 1;
        in_wave   = 1'b1;
        data_cnt  = 0;
        have_prev = 1'b0;                                  // ramp restarts each waveform
    endtask

    task automatic check_data(input acq_data_t d);
        logic [SAMPLE_W-1:0] nxt;
        int                  i;
        if (!in_wave) begin
            report_failure("data word arrived outside a waveform");
        end
        data_cnt = data_cnt + 1;
        if (have_prev) begin
            nxt = last_sample + 1'b1;                      // modulo 4096
            if (d.lane[0].sample != nxt && lfsr_q) begin
                soft_cnt = soft_cnt + 1;
            end else begin
                check_value("word_start", 64'(nxt), 64'(d.lane[0].sample));
            end
        end
        for (i = 0; i < 8; i = i + 1) begin
            check_value("lane_pad", 64'd0, 64'(d.lane[i].pad));
            check_value("lane_ovr", 64'(d.lane[i].sample[3:0] == 4'd0), 64'(d.lane[i].ovr));
            if (i > 0) begin
                nxt = d.lane[i-1].sample + 1'b1;
                check_value("lane_sample", 64'(nxt), 64'(d.lane[i].sample));
            end
        end
        last_sample = d.lane[7].sample;
        have_prev   = 1'b1;
    endtask

    task automatic finish_fill();
        if (in_wave) begin
            close_wave();
        end
        check_value("waveforms", 64'(cfg_q.num_waves), 64'(wave_cnt));
        done_cnt = done_cnt + 1;
        wave_cnt = 0;
        exp_fill = exp_fill + 1'b1;                        // 24 bit wrap
    endtask

    ////////////////////////////////////////
    // port monitor, pre-edge values
    ////////////////////////////////////////
    always @(posedge adc_clk) begin
        if (!reset && active) begin
            if (psel && penable) begin
                check_value("pready", 64'd1, 64'(pready));  // apb access phase
            end
            if (hold_q && (!out_valid || acq_out != held_q)) begin
                report_failure("held output word changed before it was taken");
            end
            if (gated && out_valid) begin
                report_failure("output word after a trigger that should be ignored");
            end else if (out_valid && out_ready) begin
                if (acq_out.hdr.kind == HDR_KIND) begin
                    check_header(acq_out.hdr);
                end else begin
                    check_data(acq_out.data);              // lane 7 pad keeps it off 4'hA
                end
            end
            if (acq_done) begin
                finish_fill();
            end
        end
        hold_q = out_valid && !out_ready;
        held_q = acq_out;
    end

    task automatic end_test(input logic [APB_DW-1:0] status);
        check_value("acq_done_pulses", gated ? 64'd0 : 64'd1, 64'(done_cnt));
        check_value("status_fill_num", 64'(exp_fill), 64'(status[FILL_NUM_W-1:0]));
        check_value("status_busy", 64'd0, 64'(status[FILL_NUM_W]));
        if (soft_cnt != 0 && !status[FILL_NUM_W+1]) begin   // overrun bit
            report_failure("data word gap or short waveform while overrun is clear");
        end
        tests_run = tests_run + 1;
        if (test_err != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %0s: %0s, %0d errors", name_q, (test_err == 0) ? "ok" : "FAILED",
            test_err);
        active = 1'b0;
    endtask

    task automatic summary();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
    endtask

endmodule

/* tests/acq_tb.sv */
`timescale 1ns/1ps

module acq_tb import acq_pkg::*; ();

    localparam int DONE_TIMEOUT = 20000;                   // cycles allowed for one fill
    localparam int GATE_WAIT    = 200;                     // quiet window after a gated trigger

    logic                adc_clk   = 1'b0;
    logic                reset     = 1'b1;
    logic                psel, penable, pwrite;
    logic [APB_AW-1:0]   paddr;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic [SAMPLE_W-1:0] adc_data  = '0;
    logic                adc_ovr   = 1'b1;                 // sample 0 has a zero low nibble
    logic                acq_trig;
    acq_word_u           acq_out;
    logic                out_valid;
    logic                out_ready = 1'b1;
    logic                acq_done;
    logic                lfsr_mode = 1'b0;                 // ready from the lfsr when set
    logic [31:0]         lfsr      = 32'h0186e918;
    logic                aborted   = 1'b0;                 // timeout or missing trace

    always #5 adc_clk = ~adc_clk;                          // 100 MHz

    acq_top dut0 (.adc_clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .adc_data, .adc_ovr, .acq_trig, .acq_out, .out_valid, .out_ready, .acq_done);

    acq_checker chk0 (.adc_clk, .reset, .psel, .penable, .pready, .acq_out, .out_valid,
        .out_ready, .acq_done);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32 22 2 1
    endfunction

    ////////////////////////////////////////
    // adc ramp and sink ready, falling edge
    ////////////////////////////////////////
    always @(negedge adc_clk) begin
        adc_data = adc_data + 1'b1;                        // wraps at 4096
        adc_ovr  = (adc_data[3:0] == 4'd0);
        if (lfsr_mode) begin
            lfsr      = lfsr_next(lfsr);                   // one step per ready bit
            out_ready = lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        @(negedge adc_clk);
        psel    = 1'b1;                                    // setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge adc_clk);
        penable = 1'b1;                                    // access phase
        @(negedge adc_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        @(negedge adc_clk);
        psel    = 1'b1;
        paddr   = addr;
        @(negedge adc_clk);
        penable = 1'b1;
        @(negedge adc_clk);
        data    = prdata;                                  // no wait states, mid cycle
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_done(input logic [127:0] name);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge adc_clk);
            seen   = acq_done;                             // pulse spans a full cycle
            cycles = cycles + 1;
        end
        if (!seen) begin
            $display("%0s: no acq_done within %0d cycles", name, DONE_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic run_test(input logic [127:0] name, input acq_cfg_t cfg,
                            input logic init_wr, input logic [31:0] init_fill,
                            input logic lfsr_on);
        logic [APB_DW-1:0] status;
        chk0.start_test(name, cfg, init_wr, init_fill[FILL_NUM_W-1:0], lfsr_on);
        apb_write(ADDR_TAG, 32'(cfg.chan_tag));
        apb_write(ADDR_MUON, 32'(cfg.muon_bursts));
        apb_write(ADDR_LASER, 32'(cfg.laser_bursts));
        apb_write(ADDR_PED, 32'(cfg.ped_bursts));
        apb_write(ADDR_WAVES, 32'(cfg.num_waves));
        if (init_wr) begin
            apb_write(ADDR_INIT, init_fill);
        end
        apb_write(ADDR_CTRL, {29'd0, cfg.fill_type, cfg.enable});
        lfsr_mode = lfsr_on;
        @(negedge adc_clk);
        acq_trig  = 1'b1;                                  // single cycle trigger
        @(negedge adc_clk);
        acq_trig  = 1'b0;
        if (!cfg.enable || cfg.fill_type == FILL_NONE) begin
            repeat (GATE_WAIT) @(negedge adc_clk);         // must stay silent
        end else begin
            wait_done(name);
        end
        lfsr_mode = 1'b0;
        repeat (2) @(negedge adc_clk);
        apb_read(ADDR_STATUS, status);
        apb_write(ADDR_STATUS, '0);                        // clear sticky overrun
        chk0.end_test(status);
    endtask

    ////////////////////////////////////////
    // trace driven test sequence
    ////////////////////////////////////////
    initial begin
        int               fd, code, n_tests;
        int               en, ftype, muon, laser, ped, waves, init_wr, ready;
        logic [31:0]      init_fill, tag;
        logic [127:0]     name;
        logic [8*160-1:0] text_line;
        acq_cfg_t         cfg;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        acq_trig = 1'b0;
        n_tests  = 0;
        repeat (5) @(negedge adc_clk);                     // five reset cycles
        reset = 1'b0;
        fd = $fopen("tests/acq_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/acq_trace.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                text_line = '0;
                code = $fgets(text_line, fd);
                if (code != 0) begin
                    code = $sscanf(text_line, "%s %d %d %d %d %d %d %d %h %h %d", name, en,
                        ftype, muon, laser, ped, waves, init_wr, init_fill, tag, ready);
                    if (code == 11) begin                  // comment lines fall out here
                        cfg.enable       = en[0];
                        cfg.fill_type    = fill_type_e'(ftype[1:0]);
                        cfg.chan_tag     = tag[TAG_W-1:0];
                        cfg.muon_bursts  = BURST_MAX_W'(muon);
                        cfg.laser_bursts = BURST_MAX_W'(laser);
                        cfg.ped_bursts   = BURST_MAX_W'(ped);
                        cfg.num_waves    = WAVE_W'(waves);
                        run_test(name, cfg, init_wr[0], init_fill, ready[0]);
                        n_tests = n_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
        if (!aborted && n_tests == 0) begin
            $display("no test lines found in tests/acq_trace.txt");
            aborted = 1'b1;
        end
        chk0.summary();
        if (!aborted && chk0.err_total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tests/acq_trace.txt */
# name en type muon laser ped waves init_wr init_fill(hex) tag(hex) ready
# type 0 muon 1 laser 2 pedestal 3 reserved, ready 0 always high 1 lfsr
muon_basic    1 0 2 3 1 2 1 000010 a5c3 0
laser_basic   1 1 2 3 1 3 0 000000 0f0f 0
ped_basic     1 2 4 1 2 1 0 000000 1234 0
muon_wrap     1 0 5 2 2 3 1 fffffe beef 0
ped_empty     1 2 3 3 0 2 0 000000 0e0e 0
gate_enable   0 0 2 2 2 1 0 000000 0001 0
gate_type3    1 3 2 2 2 1 0 000000 0002 0
muon_stall    1 0 3 2 2 3 0 000000 cafe 1
laser_stall   1 1 1 6 1 2 1 000100 7e57 1
ped_stall     1 2 2 2 4 4 0 000000 5a5a 1
gate_again    0 1 2 2 2 2 0 000000 0003 0
muon_after    1 0 1 1 1 1 0 000000 0bad 0
laser_long    1 1 1 8 1 5 1 00abcd 4242 0

/* flist.f */
source/acq_pkg.sv
source/acq_regs.sv
source/acq_header_gen.sv
source/acq_sample_packer.sv
source/acq_sequencer.sv
source/acq_top.sv
tests/acq_checker.sv
tests/acq_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module acq_tb -f flist.f -o acq_sim \
    && ./obj_dir/acq_sim | tee sim.log
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "run passed" \
    || { echo "run failed"; exit 1; }
